// ==== design/f2_pkg.sv ====
`default_nettype none

package f2_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // CPU bus

    localparam int CPU_ADDR_W = 23;  // Word address, A23..A1

    typedef logic [CPU_ADDR_W-1:0] cpu_addr_t;
    typedef logic [15:0]           cpu_data_t;

    localparam int REGION_W = 7;  // Top address bits
    localparam logic [REGION_W-1:0] WORK_REGION = 7'h10;  // 0x200000
    localparam logic [REGION_W-1:0] IO_REGION   = 7'h18;  // 0x300000

    localparam logic [2:0] FC_IACK       = 3'b111;
    localparam logic [2:0] IRQ_VBL_LEVEL = 3'd5;
    localparam logic [2:0] IRQ_DMA_LEVEL = 3'd6;

    typedef struct packed {
        logic      as_n;
        logic      rw;    // 1 is read
        logic [1:0] ds_n; // Upper, lower
        logic [2:0] fc;
        cpu_addr_t addr;
        cpu_data_t wdata;
    } cpu_bus_t;

    ////////////////////////////////////////////////////////////////////////////
    // Work RAM and save state

    localparam int WORK_ADDR_W = 8;

    typedef logic [WORK_ADDR_W-1:0] work_addr_t;

    typedef struct packed {
        logic       valid;
        logic       we;
        logic [1:0] be_n; // Upper, lower
        work_addr_t addr;
        cpu_data_t  wdata;
    } ram_req_t;

    localparam int SS_SLOT_W  = 2;
    localparam int DDR_ADDR_W = 32;

    typedef logic [SS_SLOT_W-1:0]  ss_slot_t;
    typedef logic [DDR_ADDR_W-1:0] ddr_addr_t;

    // Slot s, word i lives at SS_BASE + s * 256 + i
    localparam ddr_addr_t SS_BASE = 32'h0010_0000;

    typedef enum logic [2:0] {
        SS_IDLE,
        SS_WAIT_BUS,
        SS_SAVE_READ,
        SS_SAVE_WRITE,
        SS_RESTORE_READ,
        SS_RESTORE_WAIT,
        SS_RESTORE_WRITE
    } ss_state_t;

endpackage

`default_nettype wire

// ==== design/input_ports.sv ====
`timescale 1ns/1ps
`default_nettype none

module input_ports (
    input  logic       clk,
    input  logic [1:0] port_sel,
    input  logic [7:0] joystick_p1,
    input  logic [7:0] joystick_p2,
    input  logic [1:0] start,
    input  logic [7:0] dswa,
    input  logic [7:0] dswb,
    output logic [7:0] port_data
);

logic [7:0] port_bytes [4];

// Board wiring: start, buttons 6..4, then directions 0..3 reversed
function automatic logic [7:0] joy_byte(input logic st, input logic [7:0] joy);
    return {st, joy[6:4], joy[0], joy[1], joy[2], joy[3]};
endfunction

always_comb begin
    port_bytes[0] = dswa;
    port_bytes[1] = dswb;
    port_bytes[2] = joy_byte(start[0], joystick_p1);
    port_bytes[3] = joy_byte(start[1], joystick_p2);
end

always_ff @(posedge clk) begin
    port_data <= ~port_bytes[port_sel];  // Active low
end

endmodule

`default_nettype wire

// ==== design/irq_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module irq_ctrl (
    input  logic       clk,
    input  logic       reset,
    input  logic       vblank_n,
    input  logic       dma_n,
    input  logic       irq_ack,
    input  logic [2:0] irq_ack_level,
    output logic [2:0] cpu_ipl_n
);

logic vbl_prev;
logic dma_prev;
logic pend_vbl;   // Level 5
logic pend_dma;   // Level 6

always_ff @(posedge clk) begin
    vbl_prev <= vblank_n;
    dma_prev <= dma_n;

    if (reset) begin
        pend_vbl <= 1'b0;
        pend_dma <= 1'b0;
    end else begin
        if (vbl_prev && !vblank_n) begin  // Falling edge
            pend_vbl <= 1'b1;
        end
        if (!dma_prev && dma_n) begin     // Rising edge
            pend_dma <= 1'b1;
        end

        // Acknowledge beats a same-cycle edge
        if (irq_ack && irq_ack_level == f2_pkg::IRQ_VBL_LEVEL) begin
            pend_vbl <= 1'b0;
        end
        if (irq_ack && irq_ack_level == f2_pkg::IRQ_DMA_LEVEL) begin
            pend_dma <= 1'b0;
        end
    end
end

always_comb begin
    if (pend_dma) begin
        cpu_ipl_n = ~f2_pkg::IRQ_DMA_LEVEL;
    end else if (pend_vbl) begin
        cpu_ipl_n = ~f2_pkg::IRQ_VBL_LEVEL;
    end else begin
        cpu_ipl_n = 3'b111;
    end
end

endmodule

`default_nettype wire

// ==== design/work_ram_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module work_ram_arbiter (
    input  logic              clk,
    input  logic              reset,
    input  logic              ss_hold,

    input  f2_pkg::ram_req_t  cpu_ram_req,
    output logic              cpu_ram_grant,

    input  f2_pkg::ram_req_t  ss_ram_req,
    output logic              ss_ram_grant,

    output f2_pkg::cpu_data_t ram_rdata
);

f2_pkg::cpu_data_t mem [2**f2_pkg::WORK_ADDR_W];
f2_pkg::ram_req_t  req;

// Engine owns the RAM for the whole of ss_hold
assign cpu_ram_grant = !ss_hold && cpu_ram_req.valid;
assign ss_ram_grant  = ss_hold && ss_ram_req.valid;
assign req           = ss_hold ? ss_ram_req : cpu_ram_req;

always_ff @(posedge clk) begin
    if (req.valid) begin
        if (req.we && !reset) begin
            if (!req.be_n[1]) begin
                mem[req.addr][15:8] <= req.wdata[15:8];
            end
            if (!req.be_n[0]) begin
                mem[req.addr][7:0] <= req.wdata[7:0];
            end
        end
        ram_rdata <= mem[req.addr];  // Old data on a write
    end
end

endmodule

`default_nettype wire

// ==== design/save_state_engine.sv ====
`timescale 1ns/1ps
`default_nettype none

module save_state_engine (
    input  logic              clk,
    input  logic              reset,
    input  logic              ss_do_save,
    input  logic              ss_do_restore,
    input  f2_pkg::ss_slot_t  ss_index,
    output logic              ss_busy,

    input  logic              bus_idle,
    output logic              ss_hold,

    output f2_pkg::ram_req_t  ss_ram_req,
    input  logic              ss_ram_grant,
    input  f2_pkg::cpu_data_t ram_rdata,

    output f2_pkg::ddr_addr_t ddr_addr,
    output f2_pkg::cpu_data_t ddr_wdata,
    output logic              ddr_read,
    output logic              ddr_write,
    input  f2_pkg::cpu_data_t ddr_rdata,
    input  logic              ddr_busy,
    input  logic              ddr_read_complete
);

f2_pkg::ss_state_t  state;
f2_pkg::ss_slot_t   slot;
f2_pkg::work_addr_t word_idx;
f2_pkg::work_addr_t ram_word;
f2_pkg::cpu_data_t  word_buf;
logic restore;
logic rd_pend;        // RAM read data arrives this cycle
logic last_word;
logic write_accept;

assign ss_busy      = state != f2_pkg::SS_IDLE;
assign ddr_addr     = f2_pkg::SS_BASE + f2_pkg::ddr_addr_t'({slot, word_idx});
assign ddr_wdata    = word_buf;
assign ddr_read     = state == f2_pkg::SS_RESTORE_READ;
assign ddr_write    = state == f2_pkg::SS_SAVE_WRITE && !rd_pend;
assign last_word    = &word_idx;
assign write_accept = ddr_write && !ddr_busy;

// Next word is fetched while the current stream write is accepted
assign ram_word = (state == f2_pkg::SS_SAVE_WRITE) ? word_idx + 1'b1 : word_idx;

always_comb begin
    ss_ram_req.valid = state == f2_pkg::SS_SAVE_READ
                    || state == f2_pkg::SS_RESTORE_WRITE
                    || (write_accept && !last_word);
    ss_ram_req.we    = state == f2_pkg::SS_RESTORE_WRITE;
    ss_ram_req.be_n  = 2'b00;
    ss_ram_req.addr  = ram_word;
    ss_ram_req.wdata = word_buf;
end

////////////////////////////////////////////////////////////////////////////
// Sequencer

always_ff @(posedge clk) begin
    if (reset) begin
        state    <= f2_pkg::SS_IDLE;
        ss_hold  <= 1'b0;
        restore  <= 1'b0;
        rd_pend  <= 1'b0;
        word_idx <= '0;
    end else begin
        rd_pend <= 1'b0;
        case (state)
            f2_pkg::SS_IDLE: begin
                if (ss_do_save || ss_do_restore) begin
                    restore  <= !ss_do_save;  // Save wins
                    word_idx <= '0;
                    state    <= f2_pkg::SS_WAIT_BUS;
                end
            end
            f2_pkg::SS_WAIT_BUS: begin
                if (bus_idle) begin
                    ss_hold <= 1'b1;
                    state   <= restore ? f2_pkg::SS_RESTORE_READ : f2_pkg::SS_SAVE_READ;
                end
            end
            f2_pkg::SS_SAVE_READ: begin
                if (ss_ram_grant) begin
                    rd_pend <= 1'b1;
                    state   <= f2_pkg::SS_SAVE_WRITE;
                end
            end
            f2_pkg::SS_SAVE_WRITE: begin
                if (write_accept) begin
                    if (last_word) begin
                        ss_hold <= 1'b0;
                        state   <= f2_pkg::SS_IDLE;
                    end else begin
                        word_idx <= ram_word;
                        if (ss_ram_grant) begin
                            rd_pend <= 1'b1;
                        end else begin
                            state <= f2_pkg::SS_SAVE_READ;
                        end
                    end
                end
            end
            f2_pkg::SS_RESTORE_READ: begin
                if (!ddr_busy) begin
                    state <= f2_pkg::SS_RESTORE_WAIT;
                end
            end
            f2_pkg::SS_RESTORE_WAIT: begin
                if (ddr_read_complete) begin
                    state <= f2_pkg::SS_RESTORE_WRITE;
                end
            end
            f2_pkg::SS_RESTORE_WRITE: begin
                if (ss_ram_grant) begin
                    if (last_word) begin
                        ss_hold <= 1'b0;
                        state   <= f2_pkg::SS_IDLE;
                    end else begin
                        word_idx <= word_idx + 1'b1;
                        state    <= f2_pkg::SS_RESTORE_READ;
                    end
                end
            end
            default: begin
                state <= f2_pkg::SS_IDLE;
            end
        endcase
    end
end

always_ff @(posedge clk) begin
    if (state == f2_pkg::SS_IDLE && (ss_do_save || ss_do_restore)) begin
        slot <= ss_index;
    end

    if (rd_pend) begin
        word_buf <= ram_rdata;
    end else if (state == f2_pkg::SS_RESTORE_WAIT && ddr_read_complete) begin
        word_buf <= ddr_rdata;
    end
end

endmodule

`default_nettype wire

// ==== design/cpu_bus_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_bus_ctrl (
    input  logic              clk,
    input  logic              reset,
    input  f2_pkg::cpu_bus_t  cpu,

    output f2_pkg::cpu_data_t cpu_rdata,
    output logic              cpu_dtack_n,

    output f2_pkg::ram_req_t  cpu_ram_req,
    input  logic              cpu_ram_grant,
    input  f2_pkg::cpu_data_t ram_rdata,

    output logic [1:0]        port_sel,
    input  logic [7:0]        port_data,

    output logic              irq_ack,
    output logic [2:0]        irq_ack_level,

    output logic              bus_idle
);

logic [f2_pkg::REGION_W-1:0] region;
logic sel_iack;
logic sel_ram;
logic sel_port;
logic start;          // First cycle of a bus cycle
logic in_cycle;
logic ram_pending;    // Waiting for the arbiter
logic ram_capture;    // Granted last cycle, data on ram_rdata
logic fast_pending;   // Port, IACK or unmapped

////////////////////////////////////////////////////////////////////////////
// Decode

assign region   = cpu.addr[f2_pkg::CPU_ADDR_W-1 -: f2_pkg::REGION_W];
assign sel_iack = cpu.fc == f2_pkg::FC_IACK;
assign sel_ram  = !sel_iack && region == f2_pkg::WORK_REGION;
assign sel_port = !sel_iack && region == f2_pkg::IO_REGION;
assign start    = !cpu.as_n && !in_cycle;

assign port_sel      = cpu.addr[1:0];
assign irq_ack       = start && sel_iack && !cpu.ds_n[0];
assign irq_ack_level = cpu.addr[2:0];

always_comb begin
    cpu_ram_req.valid = ram_pending || (start && sel_ram);
    cpu_ram_req.we    = !cpu.rw;
    cpu_ram_req.be_n  = cpu.ds_n;
    cpu_ram_req.addr  = cpu.addr[f2_pkg::WORK_ADDR_W-1:0];
    cpu_ram_req.wdata = cpu.wdata;
end

assign bus_idle = !cpu_ram_req.valid && !ram_capture;

////////////////////////////////////////////////////////////////////////////
// Cycle tracking and DTACK

always_ff @(posedge clk) begin
    if (reset) begin
        in_cycle     <= 1'b0;
        cpu_dtack_n  <= 1'b1;
        ram_pending  <= 1'b0;
        ram_capture  <= 1'b0;
        fast_pending <= 1'b0;
    end else if (cpu.as_n) begin
        // Cycle over, release DTACK
        in_cycle     <= 1'b0;
        cpu_dtack_n  <= 1'b1;
        ram_pending  <= 1'b0;
        ram_capture  <= 1'b0;
        fast_pending <= 1'b0;
    end else begin
        if (start) begin
            in_cycle <= 1'b1;
        end
        ram_pending  <= cpu_ram_req.valid && !cpu_ram_grant;
        ram_capture  <= cpu_ram_grant;
        fast_pending <= start && !sel_ram;

        if (ram_capture || fast_pending) begin
            cpu_dtack_n <= 1'b0;
        end
    end
end

always_ff @(posedge clk) begin
    if (ram_capture) begin
        cpu_rdata <= ram_rdata;
    end else if (fast_pending) begin
        cpu_rdata <= sel_port ? {8'h00, port_data} : '0;  // Unmapped and IACK read 0
    end
end

endmodule

`default_nettype wire

// ==== design/f2_bus_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module f2_bus_core (
    input  logic              clk,
    input  logic              reset,

    input  f2_pkg::cpu_bus_t  cpu,
    output f2_pkg::cpu_data_t cpu_rdata,
    output logic              cpu_dtack_n,
    output logic [2:0]        cpu_ipl_n,

    input  logic              vblank_n,
    input  logic              dma_n,

    input  logic [7:0]        joystick_p1,
    input  logic [7:0]        joystick_p2,
    input  logic [1:0]        start,
    input  logic [7:0]        dswa,
    input  logic [7:0]        dswb,

    input  logic              ss_do_save,
    input  logic              ss_do_restore,
    input  f2_pkg::ss_slot_t  ss_index,
    output logic              ss_busy,

    // Memory stream
    output f2_pkg::ddr_addr_t ddr_addr,
    output f2_pkg::cpu_data_t ddr_wdata,
    output logic              ddr_read,
    output logic              ddr_write,
    input  f2_pkg::cpu_data_t ddr_rdata,
    input  logic              ddr_busy,
    input  logic              ddr_read_complete
);

f2_pkg::ram_req_t  cpu_ram_req;
f2_pkg::ram_req_t  ss_ram_req;
f2_pkg::cpu_data_t ram_rdata;
logic              cpu_ram_grant;
logic              ss_ram_grant;
logic              ss_hold;
logic              bus_idle;
logic              irq_ack;
logic [2:0]        irq_ack_level;
logic [1:0]        port_sel;
logic [7:0]        port_data;

cpu_bus_ctrl cpu_bus_ctrl (
    .clk,
    .reset,
    .cpu,
    .cpu_rdata,
    .cpu_dtack_n,
    .cpu_ram_req,
    .cpu_ram_grant,
    .ram_rdata,
    .port_sel,
    .port_data,
    .irq_ack,
    .irq_ack_level,
    .bus_idle
);

work_ram_arbiter work_ram_arbiter (
    .clk,
    .reset,
    .ss_hold,
    .cpu_ram_req,
    .cpu_ram_grant,
    .ss_ram_req,
    .ss_ram_grant,
    .ram_rdata
);

save_state_engine save_state_engine (
    .clk,
    .reset,
    .ss_do_save,
    .ss_do_restore,
    .ss_index,
    .ss_busy,
    .bus_idle,
    .ss_hold,
    .ss_ram_req,
    .ss_ram_grant,
    .ram_rdata,
    .ddr_addr,
    .ddr_wdata,
    .ddr_read,
    .ddr_write,
    .ddr_rdata,
    .ddr_busy,
    .ddr_read_complete
);

irq_ctrl irq_ctrl (
    .clk,
    .reset,
    .vblank_n,
    .dma_n,
    .irq_ack,
    .irq_ack_level,
    .cpu_ipl_n
);

input_ports input_ports (
    .clk,
    .port_sel,
    .joystick_p1,
    .joystick_p2,
    .start,
    .dswa,
    .dswb,
    .port_data
);

endmodule

`default_nettype wire

// ==== verification/f2_bus_core_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

module f2_bus_core_properties (
    input logic       clk,
    input logic       reset,
    input logic       as_n,
    input logic       cpu_dtack_n,
    input logic [2:0] cpu_ipl_n,
    input logic       ddr_read,
    input logic       ddr_write
);

// DTACK released one cycle after AS rises
dtack_release: assert property (@(posedge clk) disable iff (reset)
    (as_n && $past(as_n)) |-> cpu_dtack_n)
    else $error("DTACK held low with AS high");

stream_exclusive: assert property (@(posedge clk) disable iff (reset)
    !(ddr_read && ddr_write))
    else $error("Stream read and write together");

no_level_7: assert property (@(posedge clk) disable iff (reset)
    cpu_ipl_n != 3'b000)
    else $error("IPL encodes level 7");

endmodule

bind f2_bus_core f2_bus_core_properties props0 (
    .clk,
    .reset,
    .as_n        (cpu.as_n),
    .cpu_dtack_n,
    .cpu_ipl_n,
    .ddr_read,
    .ddr_write
);

`default_nettype wire

// ==== verification/tb_f2_bus_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_f2_bus_core;

logic              clk;
logic              reset;
f2_pkg::cpu_bus_t  cpu;
f2_pkg::cpu_data_t cpu_rdata;
logic              cpu_dtack_n;
logic [2:0]        cpu_ipl_n;
logic              vblank_n;
logic              dma_n;
logic [7:0]        joystick_p1;
logic [7:0]        joystick_p2;
logic [1:0]        start;
logic [7:0]        dswa;
logic [7:0]        dswb;
logic              ss_do_save;
logic              ss_do_restore;
f2_pkg::ss_slot_t  ss_index;
logic              ss_busy;
f2_pkg::ddr_addr_t ddr_addr;
f2_pkg::cpu_data_t ddr_wdata;
logic              ddr_read;
logic              ddr_write;
f2_pkg::cpu_data_t ddr_rdata;
logic              ddr_busy;
logic              ddr_read_complete;

f2_pkg::cpu_data_t shadow [256];        // Expected work RAM contents
f2_pkg::cpu_data_t saved_img [4][256];
f2_pkg::cpu_data_t ddr_mem [f2_pkg::ddr_addr_t];
f2_pkg::ddr_addr_t ddr_wr_log [$];
f2_pkg::ddr_addr_t rd_addr;
int                rd_wait;
string             lines [$];
int                mismatch_count;
int                fail_count;
int                cycles;
int                cycle_limit;

f2_bus_core dut0 (.*);

always #5 clk = ~clk;

////////////////////////////////////////////////////////////////////////////
// Memory stream model

always @(negedge clk) begin
    logic busy_now;
    busy_now = ($urandom_range(7) == 0);
    ddr_read_complete <= 1'b0;
    if (rd_wait > 0) begin
        rd_wait = rd_wait - 1;
        if (rd_wait == 0) begin
            ddr_read_complete <= 1'b1;
            ddr_rdata <= ddr_mem.exists(rd_addr) ? ddr_mem[rd_addr] : 16'h0000;
        end
    end
    ddr_busy <= busy_now;
    // Accepted at the coming rising edge
    if (ddr_write && !busy_now) begin
        ddr_mem[ddr_addr] = ddr_wdata;
        ddr_wr_log.push_back(ddr_addr);
    end
    if (ddr_read && !busy_now) begin
        rd_wait = 1 + $urandom_range(3);
        rd_addr = ddr_addr;
    end
end

always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycle_limit > 0 && cycles >= cycle_limit) begin
        fail_count = fail_count + 1;
        $display("Run stopped at the cycle limit of %0d", cycle_limit);
        end_run();
    end
end

task automatic end_run();
    $display("Errors: %0d mismatches, %0d other failures", mismatch_count, fail_count);
    if (mismatch_count + fail_count == 0) begin
        $display("sim passed");
    end else begin
        $display("sim failed");
    end
    $finish;
endtask

////////////////////////////////////////////////////////////////////////////
// Bus master

task automatic bus_cycle(input logic rw, input logic [1:0] ds_n, input logic [2:0] fc,
                         input f2_pkg::cpu_addr_t addr, input f2_pkg::cpu_data_t wdata,
                         output f2_pkg::cpu_data_t rdata);
    int waited;
    waited = 0;
    @(negedge clk);
    cpu.as_n  = 1'b0;
    cpu.rw    = rw;
    cpu.ds_n  = ds_n;
    cpu.fc    = fc;
    cpu.addr  = addr;
    cpu.wdata = wdata;
    while (cpu_dtack_n && waited < 2000) begin
        @(negedge clk);
        waited = waited + 1;
    end
    if (cpu_dtack_n) begin
        fail_count = fail_count + 1;
        $display("No DTACK within 2000 cycles for word address %h", addr);
    end
    rdata     = cpu_rdata;
    cpu.as_n  = 1'b1;
endtask

task automatic write_word(input logic [23:0] byte_addr, input f2_pkg::cpu_data_t data,
                          input logic [1:0] ds_n);
    f2_pkg::cpu_addr_t  addr;
    f2_pkg::cpu_data_t  rd;
    addr = byte_addr[23:1];
    bus_cycle(1'b0, ds_n, 3'b101, addr, data, rd);
    if (addr[22:16] == 7'h10) begin  // Work RAM region
        if (!ds_n[1]) begin
            shadow[addr[7:0]][15:8] = data[15:8];
        end
        if (!ds_n[0]) begin
            shadow[addr[7:0]][7:0] = data[7:0];
        end
    end
endtask

task automatic read_check(input logic [23:0] byte_addr, input f2_pkg::cpu_data_t expected);
    f2_pkg::cpu_data_t rd;
    bus_cycle(1'b1, 2'b00, 3'b101, byte_addr[23:1], 16'h0000, rd);
    if (rd !== expected) begin
        mismatch_count = mismatch_count + 1;
        $display("Mismatch at %0t: read %h from %h, expected %h", $time, rd, byte_addr,
                 expected);
    end
endtask

////////////////////////////////////////////////////////////////////////////
// Save state

task automatic wait_ss_idle();
    int waited;
    waited = 0;
    while (ss_busy && waited < 2000) begin
        @(negedge clk);
        waited = waited + 1;
    end
    if (ss_busy) begin
        fail_count = fail_count + 1;
        $display("Save state engine still busy after 2000 cycles");
    end
endtask

task automatic start_save(input f2_pkg::ss_slot_t slot);
    for (int i = 0; i < 256; i++) begin
        saved_img[slot][i] = shadow[i];
    end
    ddr_wr_log.delete();
    @(negedge clk);
    ss_index   = slot;
    ss_do_save = 1'b1;
    @(negedge clk);
    ss_do_save = 1'b0;
    if (!ss_busy) begin
        fail_count = fail_count + 1;
        $display("ss_busy did not rise after a save request");
    end
endtask

task automatic check_save(input f2_pkg::ss_slot_t slot);
    f2_pkg::ddr_addr_t exp_addr;
    if (ddr_wr_log.size() != 256) begin
        mismatch_count = mismatch_count + 1;
        $display("Mismatch at %0t: %0d stream writes, expected 256", $time, ddr_wr_log.size());
    end
    for (int i = 0; i < 256 && i < ddr_wr_log.size(); i++) begin
        exp_addr = 32'h0010_0000 + 32'(slot) * 256 + 32'(i);
        if (ddr_wr_log[i] != exp_addr) begin
            mismatch_count = mismatch_count + 1;
            $display("Mismatch at %0t: write %0d to %h, expected %h", $time, i,
                     ddr_wr_log[i], exp_addr);
        end else if (ddr_mem[exp_addr] !== saved_img[slot][i]) begin
            mismatch_count = mismatch_count + 1;
            $display("Mismatch at %0t: saved word %0d is %h, expected %h", $time, i,
                     ddr_mem[exp_addr], saved_img[slot][i]);
        end
    end
endtask

task automatic restore_slot(input f2_pkg::ss_slot_t slot);
    @(negedge clk);
    ss_index      = slot;
    ss_do_restore = 1'b1;
    @(negedge clk);
    ss_do_restore = 1'b0;
    wait_ss_idle();
    for (int i = 0; i < 256; i++) begin
        shadow[i] = saved_img[slot][i];
        read_check(24'h200000 + 24'(i * 2), shadow[i]);
    end
endtask

////////////////////////////////////////////////////////////////////////////
// Vector file

task automatic load_vectors();
    int    fd;
    string line;
    fd = $fopen("verification/bus_vectors.txt", "r");
    if (fd == 0) begin
        fail_count = fail_count + 1;
        $display("Could not open verification/bus_vectors.txt");
    end else begin
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 1 && line.getc(0) != "#") begin
                lines.push_back(line);
            end
        end
        $fclose(fd);
    end
endtask

initial begin
    string             op;
    logic [31:0]       a, b, c, d, e, f, g;
    f2_pkg::cpu_data_t rd;
    clk = 1'b0;
    reset = 1'b1;
    cpu = '0;
    cpu.as_n = 1'b1;
    cpu.rw = 1'b1;
    cpu.ds_n = 2'b11;
    vblank_n = 1'b1;
    dma_n = 1'b1;
    joystick_p1 = '0;
    joystick_p2 = '0;
    start = '0;
    dswa = '0;
    dswb = '0;
    ss_do_save = 1'b0;
    ss_do_restore = 1'b0;
    ss_index = '0;
    ddr_rdata = '0;
    ddr_busy = 1'b0;
    ddr_read_complete = 1'b0;
    rd_wait = 0;
    mismatch_count = 0;
    fail_count = 0;
    cycles = 0;
    void'($urandom(32'hfcffd3db));

    load_vectors();
    cycle_limit = 400 * lines.size();

    repeat (4) @(negedge clk);
    reset = 1'b0;

    for (int i = 0; i < 256; i++) begin
        write_word(24'h200000 + 24'(i * 2), {8'(i), ~8'(i)} ^ 16'h5a3c, 2'b00);
    end

    foreach (lines[n]) begin
        void'($sscanf(lines[n], "%s %h %h %h %h %h %h %h", op, a, b, c, d, e, f, g));
        case (op)
            "W": write_word(a[23:0], b[15:0], c[1:0]);
            "R": read_check(a[23:0], b[15:0]);
            "P": begin
                @(negedge clk);
                joystick_p1 = a[7:0];
                joystick_p2 = b[7:0];
                start       = c[1:0];
                dswa        = d[7:0];
                dswb        = e[7:0];
                read_check(24'h300000 + 24'(f[1:0]) * 2, g[15:0]);
            end
            "V": begin
                @(negedge clk);
                vblank_n = 1'b0;
                repeat (2) @(negedge clk);
                vblank_n = 1'b1;
            end
            "D": begin
                @(negedge clk);
                dma_n = 1'b0;
                repeat (2) @(negedge clk);
                dma_n = 1'b1;
            end
            "Q": begin
                @(negedge clk);
                if (cpu_ipl_n !== ~a[2:0]) begin
                    mismatch_count = mismatch_count + 1;
                    $display("Mismatch at %0t: ipl_n %b, expected level %0d", $time,
                             cpu_ipl_n, a[2:0]);
                end
            end
            "A": bus_cycle(1'b1, 2'b00, 3'b111, f2_pkg::cpu_addr_t'(a[2:0]), 16'h0000, rd);
            "S": begin
                start_save(a[1:0]);
                wait_ss_idle();
                check_save(a[1:0]);
            end
            "L": restore_slot(a[1:0]);
            "T": begin
                // Bus write lands while the engine holds the RAM
                start_save(a[1:0]);
                write_word(b[23:0], c[15:0], 2'b00);
                if (ss_busy) begin
                    fail_count = fail_count + 1;
                    $display("Stalled RAM write finished before the save ended");
                end
                wait_ss_idle();
                check_save(a[1:0]);
            end
            default: begin
                fail_count = fail_count + 1;
                $display("Unknown vector operation %s", op);
            end
        endcase
    end

    repeat (2) @(negedge clk);
    end_run();
end

endmodule

`default_nettype wire

// ==== src.f ====
design/f2_pkg.sv
design/input_ports.sv
design/irq_ctrl.sv
design/work_ram_arbiter.sv
design/save_state_engine.sv
design/cpu_bus_ctrl.sv
design/f2_bus_core.sv
verification/f2_bus_core_properties.sv
verification/tb_f2_bus_core.sv

// ==== Makefile ====
# Verilator build and run for the f2_bus_core testbench

TOP := tb_f2_bus_core
LOG := sim.log

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): src.f design/*.sv verification/*.sv
	verilator --binary --timing --assert -Wall -f src.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "sim passed" $(LOG)

lint:
	verilator --lint-only --timing -Wall -f src.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)

// ==== verification/bus_vectors.txt ====
# W byte_addr data ds_n | R byte_addr expected | A level | Q expected_level | V | D
# P joy1 joy2 start dswa dswb port expected | S slot | L slot | T slot byte_addr data
W 200010 1234 0
R 200010 1234
W 200010 abcd 1
W 200010 99ef 2
R 200010 abef
W 200020 cafe 0
R 200020 cafe
R 100000 0000
W 100000 ffff 0
R 100000 0000
P 5a c3 1 12 f0 0 00ed
P 5a c3 1 12 f0 1 000f
P 5a c3 1 12 f0 2 002a
P 5a c3 1 12 f0 3 00b3
P ff 00 2 00 00 2 0080
P ff 00 2 00 00 3 007f
P 0f 00 3 00 00 2 0070
Q 0
V
Q 5
D
Q 6
A 6
Q 5
A 5
Q 0
S 1
W 200010 5555 0
W 200030 7777 0
R 200010 5555
L 1
R 200010 abef
T 2 200040 1357
R 200040 1357
L 2
R 200040 7ae3
